//--- common/ifetch_pkg.sv
// Instruction prefetch shared definitions

package ifetch_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int ADDR_W = 32;  // Default address and fetch word width
  localparam int HALF_W = 16;  // Compressed instruction and buffered half-word

  // Program counter steps for full and compressed instructions
  localparam int INC_FULL = 4;
  localparam int INC_HALF = 2;

  // Low opcode bits of a 32-bit instruction
  // Every other value starts a compressed one
  localparam logic [1:0] OPC_FULL = 2'b11;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Where the offered instruction comes from
  //                 upper  lower
  //  FULL_ALIGNED   [iiii, iiii] held word
  //  C_ALIGNED      [xxxx, iiii] held word
  //  C_MISALIGNED   [iiii, xxxx] held word
  //  C_IN_BUF       [iiii]       half-word buffer alone
  //  SPLIT_IN_BUF   low half from the buffer, high half from the held word
  typedef enum logic [2:0] {
    FULL_ALIGNED,
    C_ALIGNED,
    C_MISALIGNED,
    C_IN_BUF,
    SPLIT_IN_BUF
  } instr_fmt_e;

  // Steps of one memory access
  typedef enum logic [1:0] {
    IDLE,          // No access in flight
    WAIT_GNT,      // Request out, grant still missing
    WAIT_RVALID,   // Granted, waiting for the data beat
    WAIT_ABORTED   // Granted before a branch, response gets dropped
  } fetch_state_e;

endpackage

//--- prefetch/fetch_ctrl.sv
// Instruction memory bus controller
`timescale 1ns/10ps

module fetch_ctrl import ifetch_pkg::*; #(
  parameter int ADDR_W = ifetch_pkg::ADDR_W
) (
  input  logic              clk,
  input  logic              rst_n,

  // Redirect from the decoder side
  input  logic              branch_i,

  // Word requests from the realigner
  input  logic              word_req_i,
  input  logic [ADDR_W-1:0] word_addr_i,
  input  logic              word_take_i,
  output logic              word_valid_o,
  output logic [ADDR_W-1:0] word_data_o,

  // Instruction memory
  output logic              instr_req_o,
  output logic [ADDR_W-1:0] instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic [ADDR_W-1:0] instr_rdata_i,
  input  logic              instr_rvalid_i,

  output logic              busy_o
);

  fetch_state_e      state_q, state_d;  // Bus access FSM
  logic [ADDR_W-1:0] addr_q;            // Address of the access that left IDLE
  logic              word_valid_q;      // Captured word is waiting for the realigner
  logic [ADDR_W-1:0] word_data_q;

  logic              issue;    // New request straight out of IDLE
  logic              capture;  // Response that belongs to a live access

  // A fresh request needs an empty capture register
  // A branch in the same cycle would leave the address stale, so it waits a cycle
  assign issue   = (state_q == IDLE) && word_req_i && !word_valid_q && !branch_i;
  assign capture = (state_q == WAIT_RVALID) && instr_rvalid_i && !branch_i;

  // The request stays up in WAIT_GNT even on a branch, since a grant may still land
  assign instr_req_o  = issue || (state_q == WAIT_GNT);
  assign instr_addr_o = (state_q == IDLE) ? {word_addr_i[ADDR_W-1:2], 2'b00}
                                          : addr_q;  // Frozen until granted

  assign word_valid_o = word_valid_q;
  assign word_data_o  = word_data_q;

  assign busy_o = (state_q != IDLE) || instr_req_o;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (issue) begin
          state_d = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        if (instr_gnt_i) begin
          // Granted in the branch cycle means a response is coming that nobody wants
          state_d = branch_i ? WAIT_ABORTED : WAIT_RVALID;
        end else if (branch_i) begin
          state_d = IDLE;  // Nothing was granted, so nothing to drain
        end
      end

      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          state_d = IDLE;  // Data is captured or dropped, either way the access is over
        end else if (branch_i) begin
          state_d = WAIT_ABORTED;
        end
      end

      WAIT_ABORTED: begin
        if (instr_rvalid_i) begin
          state_d = IDLE;  // Stale beat swallowed here
        end
      end

      default: state_d = IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      word_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // A branch flushes the held word along with the access
      if (branch_i) begin
        word_valid_q <= 1'b0;
      end else if (capture) begin
        word_valid_q <= 1'b1;
      end else if (word_take_i) begin
        word_valid_q <= 1'b0;
      end
    end
  end

  // Payload of the access and of the response
  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q <= {word_addr_i[ADDR_W-1:2], 2'b00};
    end
    if (capture) begin
      word_data_q <= instr_rdata_i;  // Held until the realigner takes it
    end
  end

endmodule

//--- prefetch/instr_align.sv
// Instruction realigner and program counter
`timescale 1ns/10ps

module instr_align import ifetch_pkg::*; #(
  parameter int ADDR_W = ifetch_pkg::ADDR_W
) (
  input  logic              clk,
  input  logic              rst_n,

  // Decoder side
  input  logic              req_i,
  input  logic              branch_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              ready_i,
  output logic              valid_o,
  output logic [ADDR_W-1:0] rdata_o,
  output logic [ADDR_W-1:0] addr_o,

  // Word path from the bus controller
  output logic              word_req_o,
  output logic [ADDR_W-1:0] word_addr_o,
  input  logic              word_valid_i,
  input  logic [ADDR_W-1:0] word_data_i,
  output logic              word_take_o
);

  logic [ADDR_W-1:0] pc_q;          // Address of the next instruction to deliver
  logic [HALF_W-1:0] buf_q;         // Upper half of the last consumed word
  logic              buf_valid_q;   // Buffer holds data from the sequential stream
  logic              split_q;       // First half of a straddling instruction is in buf_q
  logic [ADDR_W-1:0] split_addr_q;  // Start address of that instruction

  instr_fmt_e        fmt;
  logic              offer;        // An instruction can be presented
  logic              split_word;   // Straddle found in the held word
  logic              split_buf;    // Straddle found in the buffer
  logic              buf_trusted;
  logic              transfer;
  logic              uses_word;    // Format consumes the held word
  logic [ADDR_W-1:0] pc_next;

  // The buffer only stands in for the upper half of the word at pc
  assign buf_trusted = buf_valid_q && pc_q[1] && !split_q;

  //////////////////////////////////////////////////
  // Format selection
  //////////////////////////////////////////////////

  always_comb begin
    fmt        = FULL_ALIGNED;
    offer      = 1'b0;
    split_word = 1'b0;
    split_buf  = 1'b0;
    if (split_q) begin
      // Waiting for the word with the second half
      fmt   = SPLIT_IN_BUF;
      offer = word_valid_i;
    end else if (buf_trusted) begin
      fmt = SPLIT_IN_BUF;
      if (buf_q[1:0] != OPC_FULL) begin
        fmt   = C_IN_BUF;  // Served without any bus access
        offer = 1'b1;
      end else begin
        split_buf = 1'b1;
      end
    end else if (word_valid_i) begin
      if (!pc_q[1]) begin
        fmt   = (word_data_i[1:0] == OPC_FULL) ? FULL_ALIGNED : C_ALIGNED;
        offer = 1'b1;
      end else if (word_data_i[HALF_W+1:HALF_W] != OPC_FULL) begin
        fmt   = C_MISALIGNED;  // Only reached right after a branch to pc[1] set
        offer = 1'b1;
      end else begin
        fmt        = SPLIT_IN_BUF;
        split_word = 1'b1;  // Park the upper half and go for the next word
      end
    end
  end

  // Build the instruction, compressed ones are zero-extended
  always_comb begin
    unique case (fmt)
      FULL_ALIGNED: rdata_o = word_data_i;
      C_ALIGNED:    rdata_o = {{(ADDR_W-HALF_W){1'b0}}, word_data_i[HALF_W-1:0]};
      C_MISALIGNED: rdata_o = {{(ADDR_W-HALF_W){1'b0}}, word_data_i[2*HALF_W-1:HALF_W]};
      C_IN_BUF:     rdata_o = {{(ADDR_W-HALF_W){1'b0}}, buf_q};
      SPLIT_IN_BUF: rdata_o = {word_data_i[ADDR_W-HALF_W-1:0], buf_q};
      default:      rdata_o = word_data_i;
    endcase
  end

  // A branch throws away whatever is on offer
  assign valid_o  = offer && !branch_i;
  assign addr_o   = split_q ? split_addr_q : pc_q;
  assign transfer = valid_o && ready_i;

  // One adder for every step, the split start also moves by a half-word
  assign pc_next = pc_q + ((fmt == FULL_ALIGNED) ? ADDR_W'(INC_FULL) : ADDR_W'(INC_HALF));

  //////////////////////////////////////////////////
  // Word handshake
  //////////////////////////////////////////////////

  assign uses_word   = (fmt != C_IN_BUF);
  // The straddle start takes the word even under back-pressure
  assign word_take_o = !branch_i && ((transfer && uses_word) || split_word);

  // Request level holds the address until the word shows up
  assign word_req_o  = req_i && (split_q || !buf_trusted) && !word_valid_i;
  assign word_addr_o = {pc_q[ADDR_W-1:2], 2'b00};

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q        <= '0;
      buf_valid_q <= 1'b0;
      split_q     <= 1'b0;
    end else if (branch_i) begin
      pc_q        <= addr_i;  // Redirect and forget the sequential state
      buf_valid_q <= 1'b0;
      split_q     <= 1'b0;
    end else begin
      if (transfer || split_word || split_buf) begin
        pc_q <= pc_next;
      end
      if (word_take_o) begin
        buf_valid_q <= 1'b1;  // Every consumed word refills the buffer
      end
      if (split_word || split_buf) begin
        split_q <= 1'b1;
      end else if (transfer) begin
        split_q <= 1'b0;
      end
    end
  end

  // Buffer contents and the saved start address
  always_ff @(posedge clk) begin
    if (word_take_o) begin
      buf_q <= word_data_i[2*HALF_W-1:HALF_W];
    end
    if (split_word || split_buf) begin
      split_addr_q <= pc_q;
    end
  end

endmodule

//--- hdl/prefetch_top.sv
// Instruction prefetch buffer
`timescale 1ns/10ps

module prefetch_top import ifetch_pkg::*; #(
  parameter int ADDR_W = ifetch_pkg::ADDR_W
) (
  input  logic              clk,
  input  logic              rst_n,

  // Decoder side
  input  logic              req_i,
  input  logic              branch_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              ready_i,
  output logic              valid_o,
  output logic [ADDR_W-1:0] rdata_o,
  output logic [ADDR_W-1:0] addr_o,

  // Instruction memory
  output logic              instr_req_o,
  output logic [ADDR_W-1:0] instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic [ADDR_W-1:0] instr_rdata_i,
  input  logic              instr_rvalid_i,

  output logic              busy_o
);

  // Word path between the realigner and the bus controller
  logic              word_req;
  logic [ADDR_W-1:0] word_addr;
  logic              word_valid;
  logic [ADDR_W-1:0] word_data;
  logic              word_take;

  //////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////

  fetch_ctrl #(
    .ADDR_W (ADDR_W)
  ) u_fetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch_i),
    .word_req_i     (word_req),
    .word_addr_i    (word_addr),
    .word_take_i    (word_take),
    .word_valid_o   (word_valid),
    .word_data_o    (word_data),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_o         (busy_o)          // Set while an access is open
  );

  //////////////////////////////////////////////////
  // Decoder side
  //////////////////////////////////////////////////

  instr_align #(
    .ADDR_W (ADDR_W)
  ) u_instr_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .branch_i     (branch_i),
    .addr_i       (addr_i),
    .ready_i      (ready_i),
    .valid_o      (valid_o),
    .rdata_o      (rdata_o),
    .addr_o       (addr_o),
    .word_req_o   (word_req),
    .word_addr_o  (word_addr),
    .word_valid_i (word_valid),
    .word_data_i  (word_data),
    .word_take_o  (word_take)
  );

endmodule

//--- verif/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset drops on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- verif/tb_checker.sv
// Instruction stream checker
`timescale 1ns/10ps

module tb_checker import ifetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        branch_i,
  input  logic [31:0] target_i,
  input  logic        ready_i,
  input  logic        dut_valid_i,
  input  logic [31:0] dut_rdata_i,
  input  logic [31:0] dut_addr_i,
  input  logic        bus_req_i,
  input  logic [31:0] bus_addr_i,
  input  logic        bus_gnt_i,
  input  logic        bus_rvalid_i,
  input  logic        busy_i,
  input  logic [31:0] mem_i [256],
  output int          err_cnt_o,
  output int          xfer_cnt_o
);

  logic [31:0] pc_m;           // Model program counter
  logic        reset_seen;     // First cycle out of reset was checked
  logic        pend_req;       // Request seen without a grant
  logic [31:0] pend_addr;
  logic        outstanding;    // Granted access still unanswered
  logic        held;           // Offer stalled by the decoder last cycle
  logic [31:0] held_rdata;
  logic [31:0] held_addr;

  // Half-word of memory at a byte address
  function automatic logic [15:0] half_at(input logic [31:0] a);
    logic [31:0] w;
    w = mem_i[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    err_cnt_o = err_cnt_o + 1;
  endtask

  initial begin
    err_cnt_o   = 0;
    xfer_cnt_o  = 0;
    pc_m        = '0;
    reset_seen  = 1'b0;
    pend_req    = 1'b0;
    outstanding = 1'b0;
    held        = 1'b0;
  end

  //////////////////////////////////////////////////
  // Bus protocol
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (dut_valid_i || bus_req_i || busy_i)
          fail("valid, request or busy high right after reset");
      end
      // Busy covers a request on the bus and any unanswered access
      if (busy_i != (bus_req_i || outstanding))
        fail($sformatf("busy %b with request %b and open access %b",
                       busy_i, bus_req_i, outstanding));
      if (bus_req_i && bus_addr_i[1:0] != 2'b00)
        fail($sformatf("request address %h not word-aligned", bus_addr_i));
      if (pend_req && (!bus_req_i || bus_addr_i != pend_addr))
        fail("request dropped or changed before its grant");
      if (bus_rvalid_i) begin
        if (!outstanding)
          fail("response without an open access");
        outstanding = 1'b0;
      end
      if (bus_req_i && outstanding)
        fail("new request while an access is still open");
      if (bus_req_i && bus_gnt_i)
        outstanding = 1'b1;
      // A branch may withdraw a request that was never granted
      pend_req  = bus_req_i && !bus_gnt_i && !branch_i;
      pend_addr = bus_addr_i;
    end
  end

  //////////////////////////////////////////////////
  // Instruction stream
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [15:0] lo;
    logic [31:0] exp_data;
    if (rst_n) begin
      // A stalled offer stays put unless a branch kills it
      if (held && !branch_i) begin
        if (!dut_valid_i || dut_rdata_i != held_rdata || dut_addr_i != held_addr)
          fail("offer changed while the decoder stalled");
      end
      held = dut_valid_i && !ready_i && !branch_i;
      held_rdata = dut_rdata_i;
      held_addr  = dut_addr_i;

      if (branch_i) begin
        pc_m = target_i;  // Redirect overrides any transfer
      end else if (dut_valid_i && ready_i) begin
        lo = half_at(pc_m);
        if (lo[1:0] != OPC_FULL)
          exp_data = {16'h0000, lo};
        else
          exp_data = {half_at(pc_m + 32'd2), lo};
        if (dut_addr_i != pc_m)
          fail($sformatf("addr %h, expected %h", dut_addr_i, pc_m));
        if (dut_rdata_i != exp_data)
          fail($sformatf("rdata %h at %h, expected %h", dut_rdata_i, pc_m, exp_data));
        pc_m = pc_m + ((lo[1:0] != OPC_FULL) ? 32'd2 : 32'd4);
        xfer_cnt_o = xfer_cnt_o + 1;
      end
    end
  end

endmodule

//--- verif/tb_prefetch.sv
// Prefetch buffer testbench
`timescale 1ns/10ps

module tb_prefetch;

  localparam int N_TESTS = 5;
  localparam int N_XFER  = 400;
  // Worst transfer is one full word: 3 grant + 4 rvalid + capture, doubled by random ready
  localparam int CYC_PER_XFER = 20;
  localparam int MAX_CYCLES   = N_TESTS * N_XFER * CYC_PER_XFER + 200;

  logic        clk, rst_n;
  logic        req, branch, ready;
  logic [31:0] target;
  logic        valid, busy;
  logic [31:0] rdata, addr;
  logic        instr_req, instr_gnt, instr_rvalid;
  logic [31:0] instr_addr, instr_rdata;
  logic [31:0] mem [256];
  logic [31:0] lfsr;
  int          err_cnt, xfer_cnt, cycles, failed_tests;

  tb_clock #(.PERIOD_NS(100), .RST_CYCLES(10)) u_clock (.clk_o(clk), .rst_n_o(rst_n));

  prefetch_top #(.ADDR_W(32)) UUT (
    .clk(clk), .rst_n(rst_n), .req_i(req), .branch_i(branch), .addr_i(target),
    .ready_i(ready), .valid_o(valid), .rdata_o(rdata), .addr_o(addr),
    .instr_req_o(instr_req), .instr_addr_o(instr_addr), .instr_gnt_i(instr_gnt),
    .instr_rdata_i(instr_rdata), .instr_rvalid_i(instr_rvalid), .busy_o(busy)
  );

  tb_checker u_checker (
    .clk(clk), .rst_n(rst_n), .branch_i(branch), .target_i(target),
    .ready_i(ready), .dut_valid_i(valid), .dut_rdata_i(rdata), .dut_addr_i(addr),
    .bus_req_i(instr_req), .bus_addr_i(instr_addr), .bus_gnt_i(instr_gnt),
    .bus_rvalid_i(instr_rvalid), .busy_i(busy), .mem_i(mem),
    .err_cnt_o(err_cnt), .xfer_cnt_o(xfer_cnt)
  );

  //////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};  // One step per bit taken
    end
  endtask

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  logic        outstanding;
  logic [31:0] acc_addr;
  logic [31:0] gnt_wait, lat_cnt;

  // Accept a granted request and pick its delays
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding = 1'b0;
      gnt_wait    = '0;
      lat_cnt     = '0;
    end else begin
      if (instr_rvalid)
        outstanding = 1'b0;
      if (instr_req && instr_gnt) begin
        outstanding = 1'b1;
        acc_addr    = instr_addr;
        draw(2, lat_cnt);
        lat_cnt = lat_cnt + 32'd1;  // 1 to 4 cycles to rvalid
        draw(2, gnt_wait);          // 0 to 3 cycles to the next grant
      end
    end
  end

  always @(negedge clk) begin
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    if (rst_n) begin
      if (outstanding) begin
        if (lat_cnt != 0) begin
          lat_cnt = lat_cnt - 32'd1;
          if (lat_cnt == 0) begin
            instr_rvalid = 1'b1;
            instr_rdata  = mem[acc_addr[9:2]];
          end
        end
      end else if (gnt_wait == 0) begin
        instr_gnt = 1'b1;
      end else begin
        gnt_wait = gnt_wait - 32'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Half-words start compressed instructions about half the time
  task automatic fill_memory(input logic full_only);
    logic [31:0] w, sel;
    for (int i = 0; i < 256; i++) begin
      draw(32, w);
      draw(2, sel);
      if (full_only || sel[0])
        w[1:0] = 2'b11;
      else
        w[1] = 1'b0;
      if (sel[1])
        w[17:16] = 2'b11;
      else
        w[17] = 1'b0;
      mem[i] = w;
    end
  endtask

  task automatic run_test(input int id, input string name, input logic full_only,
                          input logic rand_ready, input logic rand_branch);
    int          err0, goal;
    logic [31:0] r;
    err0 = err_cnt;
    @(negedge clk);
    req   = 1'b0;
    ready = 1'b0;
    while (busy) @(negedge clk);  // Let any open access finish
    fill_memory(full_only);
    goal   = xfer_cnt + N_XFER;
    branch = 1'b1;
    target = '0;
    req    = 1'b1;
    while (xfer_cnt < goal) begin
      @(negedge clk);
      branch = 1'b0;
      ready  = 1'b1;
      if (rand_ready) begin
        draw(1, r);
        ready = r[0];
      end
      if (rand_branch) begin
        draw(4, r);
        if (r[3:0] == 4'd0) begin
          draw(9, r);
          branch = 1'b1;
          target = {22'd0, r[8:0], 1'b0};  // Half-word aligned targets too
        end
      end
    end
    if (err_cnt != err0)
      failed_tests++;
    $display("test %0d %s: %0d transfers, %0d errors", id, name, N_XFER, err_cnt - err0);
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    lfsr         = 32'h33ef43b5;
    cycles       = 0;
    failed_tests = 0;
    req          = 1'b0;
    branch       = 1'b0;
    ready        = 1'b0;
    target       = '0;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    for (int i = 0; i < 256; i++)
      mem[i] = '0;
    @(posedge rst_n);
    repeat (3) @(negedge clk);
    run_test(1, "reset and bus protocol", 1'b0, 1'b1, 1'b0);
    run_test(2, "full instructions", 1'b1, 1'b0, 1'b0);
    run_test(3, "mixed instructions", 1'b0, 1'b0, 1'b0);
    run_test(4, "back-pressure", 1'b0, 1'b1, 1'b0);
    run_test(5, "branches", 1'b0, 1'b1, 1'b1);
    $display("tests run: %0d, failed: %0d, errors: %0d", N_TESTS, failed_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- project.f
common/ifetch_pkg.sv
prefetch/fetch_ctrl.sv
prefetch/instr_align.sv
hdl/prefetch_top.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_prefetch.sv

//--- run.sh
#!/bin/sh
# Build and run the prefetch buffer simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f project.f --top-module tb_prefetch -o sim_prefetch
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_prefetch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "PASS: all tests" "$LOG"; then
  exit 0
fi
echo "Simulation reported failure"
exit 1
